//--- design/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h2040_0000

`endif

//--- design/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] rv_word_t;
    typedef logic [4:0] rv_reg_idx_t;

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        DECODE,
        EXECUTE,
        LOAD,
        LOAD_WAIT
    } rv_stage_e;

    typedef enum logic [5:0] {
        OP_NONE,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR,
        OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU
    } rv_op_e;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // shared by the immediate and register alu groups
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    // sub and arithmetic shifts
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

//--- design/rv_mem_if.sv
`timescale 1ns/10ps

`include "rv_config.svh"

interface rv_mem_if;

    logic               req_valid;
    logic               req_ready;
    logic [`RV_XLEN-1:0] req_addr;

    // one-cycle pulse with the read data
    logic               rsp_valid;
    logic [`RV_XLEN-1:0] rsp_data;

    modport requester (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  rsp_valid,
        input  rsp_data
    );

    modport server (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output rsp_valid,
        output rsp_data
    );

endinterface

//--- design/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder (
    input  rv_pkg::rv_word_t    i_instr,
    output rv_pkg::rv_op_e      o_op,
    output rv_pkg::rv_reg_idx_t o_rs1,
    output rv_pkg::rv_reg_idx_t o_rs2,
    output rv_pkg::rv_reg_idx_t o_rd,
    output rv_pkg::rv_word_t    o_imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];
    assign o_rd   = i_instr[11:7];

    always_comb begin
        o_op  = rv_pkg::OP_NONE;
        // i-type unless the format says otherwise
        o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
        case (opcode)
            rv_pkg::OPC_LUI: begin
                o_op  = rv_pkg::OP_LUI;
                o_imm = {i_instr[31:12], 12'b0};
            end
            rv_pkg::OPC_AUIPC: begin
                o_op  = rv_pkg::OP_AUIPC;
                o_imm = {i_instr[31:12], 12'b0};
            end
            rv_pkg::OPC_JAL: begin
                o_op  = rv_pkg::OP_JAL;
                o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                         i_instr[30:21], 1'b0};
            end
            rv_pkg::OPC_JALR: begin
                if (funct3 == rv_pkg::F3_JALR) begin
                    o_op = rv_pkg::OP_JALR;
                end
            end
            rv_pkg::OPC_BRANCH: begin
                o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                         i_instr[11:8], 1'b0};
                case (funct3)
                    rv_pkg::F3_BEQ:  o_op = rv_pkg::OP_BEQ;
                    rv_pkg::F3_BNE:  o_op = rv_pkg::OP_BNE;
                    rv_pkg::F3_BLT:  o_op = rv_pkg::OP_BLT;
                    rv_pkg::F3_BGE:  o_op = rv_pkg::OP_BGE;
                    rv_pkg::F3_BLTU: o_op = rv_pkg::OP_BLTU;
                    rv_pkg::F3_BGEU: o_op = rv_pkg::OP_BGEU;
                    default:         o_op = rv_pkg::OP_NONE;
                endcase
            end
            rv_pkg::OPC_LOAD: begin
                case (funct3)
                    rv_pkg::F3_LB:  o_op = rv_pkg::OP_LB;
                    rv_pkg::F3_LH:  o_op = rv_pkg::OP_LH;
                    rv_pkg::F3_LW:  o_op = rv_pkg::OP_LW;
                    rv_pkg::F3_LBU: o_op = rv_pkg::OP_LBU;
                    rv_pkg::F3_LHU: o_op = rv_pkg::OP_LHU;
                    default:        o_op = rv_pkg::OP_NONE;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                case (funct3)
                    rv_pkg::F3_ADD:  o_op = rv_pkg::OP_ADDI;
                    rv_pkg::F3_SLT:  o_op = rv_pkg::OP_SLTI;
                    rv_pkg::F3_SLTU: o_op = rv_pkg::OP_SLTIU;
                    rv_pkg::F3_XOR:  o_op = rv_pkg::OP_XORI;
                    rv_pkg::F3_OR:   o_op = rv_pkg::OP_ORI;
                    rv_pkg::F3_AND:  o_op = rv_pkg::OP_ANDI;
                    rv_pkg::F3_SLL: begin
                        if (funct7 == rv_pkg::F7_BASE) begin
                            o_op = rv_pkg::OP_SLLI;
                        end
                    end
                    rv_pkg::F3_SR: begin
                        if (funct7 == rv_pkg::F7_BASE) begin
                            o_op = rv_pkg::OP_SRLI;
                        end else if (funct7 == rv_pkg::F7_ALT) begin
                            o_op = rv_pkg::OP_SRAI;
                        end
                    end
                    default: o_op = rv_pkg::OP_NONE;
                endcase
            end
            rv_pkg::OPC_OP: begin
                if (funct7 == rv_pkg::F7_BASE) begin
                    case (funct3)
                        rv_pkg::F3_ADD:  o_op = rv_pkg::OP_ADD;
                        rv_pkg::F3_SLL:  o_op = rv_pkg::OP_SLL;
                        rv_pkg::F3_SLT:  o_op = rv_pkg::OP_SLT;
                        rv_pkg::F3_SLTU: o_op = rv_pkg::OP_SLTU;
                        rv_pkg::F3_XOR:  o_op = rv_pkg::OP_XOR;
                        rv_pkg::F3_SR:   o_op = rv_pkg::OP_SRL;
                        rv_pkg::F3_OR:   o_op = rv_pkg::OP_OR;
                        default:         o_op = rv_pkg::OP_AND;
                    endcase
                end else if (funct7 == rv_pkg::F7_ALT) begin
                    if (funct3 == rv_pkg::F3_ADD) begin
                        o_op = rv_pkg::OP_SUB;
                    end else if (funct3 == rv_pkg::F3_SR) begin
                        o_op = rv_pkg::OP_SRA;
                    end
                end
            end
            // fence, system and anything unknown fall through as no-ops
            default: o_op = rv_pkg::OP_NONE;
        endcase
    end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/10ps

`include "rv_config.svh"

module rv_regfile (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_we,
    input  rv_pkg::rv_reg_idx_t i_waddr,
    input  rv_pkg::rv_word_t    i_wdata,
    input  rv_pkg::rv_reg_idx_t i_raddr1,
    input  rv_pkg::rv_reg_idx_t i_raddr2,
    output rv_pkg::rv_word_t    o_rdata1,
    output rv_pkg::rv_word_t    o_rdata2
);

    rv_pkg::rv_word_t regs [`RV_NUM_REGS];

    // x0 is never written, so it keeps its reset value of zero
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

endmodule

//--- design/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
    input  rv_pkg::rv_op_e      i_op,
    input  rv_pkg::rv_word_t    i_pc,
    input  rv_pkg::rv_word_t    i_next_pc,
    input  rv_pkg::rv_word_t    i_rs1_val,
    input  rv_pkg::rv_word_t    i_rs2_val,
    input  rv_pkg::rv_word_t    i_imm,
    input  rv_pkg::rv_reg_idx_t i_shamt,
    input  logic [1:0]          i_load_addr_low,
    input  rv_pkg::rv_word_t    i_load_data,
    output logic                o_wb_en,
    output rv_pkg::rv_word_t    o_result,
    output logic                o_pc_redirect,
    output rv_pkg::rv_word_t    o_target,
    output rv_pkg::rv_word_t    o_load_addr,
    output rv_pkg::rv_word_t    o_load_result
);

    rv_pkg::rv_word_t byte_sel;
    rv_pkg::rv_word_t half_sel;

    // shared by loads and jalr
    assign o_load_addr = i_rs1_val + i_imm;

    always_comb begin
        o_wb_en       = 1'b1;
        o_result      = '0;
        o_pc_redirect = 1'b0;
        o_target      = i_pc + i_imm;
        case (i_op)
            rv_pkg::OP_LUI:   o_result = i_imm;
            rv_pkg::OP_AUIPC: o_result = i_pc + i_imm;
            rv_pkg::OP_JAL: begin
                o_result      = i_next_pc;
                o_pc_redirect = 1'b1;
            end
            rv_pkg::OP_JALR: begin
                o_result      = i_next_pc;
                o_pc_redirect = 1'b1;
                o_target      = o_load_addr & ~rv_pkg::rv_word_t'(1);
            end
            rv_pkg::OP_BEQ, rv_pkg::OP_BNE, rv_pkg::OP_BLT,
            rv_pkg::OP_BGE, rv_pkg::OP_BLTU, rv_pkg::OP_BGEU: begin
                o_wb_en = 1'b0;
                case (i_op)
                    rv_pkg::OP_BEQ:  o_pc_redirect = (i_rs1_val == i_rs2_val);
                    rv_pkg::OP_BNE:  o_pc_redirect = (i_rs1_val != i_rs2_val);
                    rv_pkg::OP_BLT:  o_pc_redirect = ($signed(i_rs1_val) < $signed(i_rs2_val));
                    rv_pkg::OP_BGE:  o_pc_redirect = ($signed(i_rs1_val) >= $signed(i_rs2_val));
                    rv_pkg::OP_BLTU: o_pc_redirect = (i_rs1_val < i_rs2_val);
                    default:         o_pc_redirect = (i_rs1_val >= i_rs2_val);
                endcase
            end
            rv_pkg::OP_ADDI:  o_result = i_rs1_val + i_imm;
            rv_pkg::OP_SLTI:
                o_result = rv_pkg::rv_word_t'($signed(i_rs1_val) < $signed(i_imm));
            rv_pkg::OP_SLTIU: o_result = rv_pkg::rv_word_t'(i_rs1_val < i_imm);
            rv_pkg::OP_XORI:  o_result = i_rs1_val ^ i_imm;
            rv_pkg::OP_ORI:   o_result = i_rs1_val | i_imm;
            rv_pkg::OP_ANDI:  o_result = i_rs1_val & i_imm;
            rv_pkg::OP_SLLI:  o_result = i_rs1_val << i_shamt;
            rv_pkg::OP_SRLI:  o_result = i_rs1_val >> i_shamt;
            rv_pkg::OP_SRAI:  o_result = $signed(i_rs1_val) >>> i_shamt;
            rv_pkg::OP_ADD:   o_result = i_rs1_val + i_rs2_val;
            rv_pkg::OP_SUB:   o_result = i_rs1_val - i_rs2_val;
            rv_pkg::OP_SLL:   o_result = i_rs1_val << i_rs2_val[4:0];
            rv_pkg::OP_SLT:
                o_result = rv_pkg::rv_word_t'($signed(i_rs1_val) < $signed(i_rs2_val));
            rv_pkg::OP_SLTU:  o_result = rv_pkg::rv_word_t'(i_rs1_val < i_rs2_val);
            rv_pkg::OP_XOR:   o_result = i_rs1_val ^ i_rs2_val;
            rv_pkg::OP_SRL:   o_result = i_rs1_val >> i_rs2_val[4:0];
            rv_pkg::OP_SRA:   o_result = $signed(i_rs1_val) >>> i_rs2_val[4:0];
            rv_pkg::OP_OR:    o_result = i_rs1_val | i_rs2_val;
            rv_pkg::OP_AND:   o_result = i_rs1_val & i_rs2_val;
            // loads write back later, from LOAD_WAIT
            default:          o_wb_en = 1'b0;
        endcase
    end

    // move the addressed byte or halfword down to bit 0
    assign byte_sel = i_load_data >> {i_load_addr_low, 3'b000};
    assign half_sel = i_load_data >> {i_load_addr_low[1], 4'b0000};

    always_comb begin
        case (i_op)
            rv_pkg::OP_LB:  o_load_result = {{24{byte_sel[7]}}, byte_sel[7:0]};
            rv_pkg::OP_LH:  o_load_result = {{16{half_sel[15]}}, half_sel[15:0]};
            rv_pkg::OP_LBU: o_load_result = {24'b0, byte_sel[7:0]};
            rv_pkg::OP_LHU: o_load_result = {16'b0, half_sel[15:0]};
            default:        o_load_result = i_load_data;
        endcase
    end

endmodule

//--- design/rv_control.sv
`timescale 1ns/10ps

`include "rv_config.svh"

module rv_control (
    input logic        i_clk,
    input logic        i_rst,
    rv_mem_if.requester mem
);

    rv_pkg::rv_stage_e   stage;
    rv_pkg::rv_word_t    pc;
    rv_pkg::rv_word_t    next_pc;
    rv_pkg::rv_word_t    ir;

    // decoded fields, held from DECODE on
    rv_pkg::rv_op_e      dec_op;
    rv_pkg::rv_reg_idx_t dec_rs1;
    rv_pkg::rv_reg_idx_t dec_rs2;
    rv_pkg::rv_reg_idx_t dec_rd;
    rv_pkg::rv_word_t    dec_imm;
    rv_pkg::rv_op_e      op_q;
    rv_pkg::rv_reg_idx_t rs1_q;
    rv_pkg::rv_reg_idx_t rs2_q;
    rv_pkg::rv_reg_idx_t rd_q;
    rv_pkg::rv_word_t    imm_q;

    rv_pkg::rv_word_t    rs1_val;
    rv_pkg::rv_word_t    rs2_val;
    logic                wb_en;
    rv_pkg::rv_word_t    result;
    logic                pc_redirect;
    rv_pkg::rv_word_t    target;
    rv_pkg::rv_word_t    load_addr;
    rv_pkg::rv_word_t    load_addr_q;
    rv_pkg::rv_word_t    load_result;
    logic                is_load;
    logic                rf_we;
    logic                req_done;

    assign is_load = op_q inside {rv_pkg::OP_LB, rv_pkg::OP_LH, rv_pkg::OP_LW,
                                  rv_pkg::OP_LBU, rv_pkg::OP_LHU};

    assign mem.req_valid = (stage == rv_pkg::FETCH) || (stage == rv_pkg::LOAD);
    assign mem.req_addr  = (stage == rv_pkg::LOAD) ? load_addr_q : next_pc;
    assign req_done      = mem.req_valid && mem.req_ready;

    // alu result in EXECUTE, load data when it returns
    assign rf_we = ((stage == rv_pkg::EXECUTE) && wb_en) ||
                   ((stage == rv_pkg::LOAD_WAIT) && mem.rsp_valid);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage   <= rv_pkg::FETCH;
            pc      <= `RV_RESET_PC;
            next_pc <= `RV_RESET_PC;
        end else begin
            case (stage)
                rv_pkg::FETCH: begin
                    if (req_done) begin
                        pc      <= next_pc;
                        next_pc <= next_pc + 4;
                        stage   <= rv_pkg::FETCH_WAIT;
                    end
                end
                rv_pkg::FETCH_WAIT: begin
                    if (mem.rsp_valid) begin
                        stage <= rv_pkg::DECODE;
                    end
                end
                rv_pkg::DECODE: begin
                    stage <= rv_pkg::EXECUTE;
                end
                rv_pkg::EXECUTE: begin
                    if (is_load) begin
                        stage <= rv_pkg::LOAD;
                    end else begin
                        if (pc_redirect) begin
                            next_pc <= target;
                        end
                        stage <= rv_pkg::FETCH;
                    end
                end
                rv_pkg::LOAD: begin
                    if (req_done) begin
                        stage <= rv_pkg::LOAD_WAIT;
                    end
                end
                rv_pkg::LOAD_WAIT: begin
                    if (mem.rsp_valid) begin
                        stage <= rv_pkg::FETCH;
                    end
                end
                default: stage <= rv_pkg::FETCH;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if ((stage == rv_pkg::FETCH_WAIT) && mem.rsp_valid) begin
            ir <= mem.rsp_data;
        end
        if (stage == rv_pkg::DECODE) begin
            op_q  <= dec_op;
            rs1_q <= dec_rs1;
            rs2_q <= dec_rs2;
            rd_q  <= dec_rd;
            imm_q <= dec_imm;
        end
        if (stage == rv_pkg::EXECUTE) begin
            load_addr_q <= load_addr;
        end
    end

    rv_decoder u_decoder (
        .i_instr (ir),
        .o_op    (dec_op),
        .o_rs1   (dec_rs1),
        .o_rs2   (dec_rs2),
        .o_rd    (dec_rd),
        .o_imm   (dec_imm)
    );

    rv_regfile u_regfile (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_we     (rf_we),
        .i_waddr  (rd_q),
        .i_wdata  ((stage == rv_pkg::LOAD_WAIT) ? load_result : result),
        .i_raddr1 (rs1_q),
        .i_raddr2 (rs2_q),
        .o_rdata1 (rs1_val),
        .o_rdata2 (rs2_val)
    );

    rv_execute u_execute (
        .i_op            (op_q),
        .i_pc            (pc),
        .i_next_pc       (next_pc),
        .i_rs1_val       (rs1_val),
        .i_rs2_val       (rs2_val),
        .i_imm           (imm_q),
        .i_shamt         (rs2_q),
        .i_load_addr_low (load_addr_q[1:0]),
        .i_load_data     (mem.rsp_data),
        .o_wb_en         (wb_en),
        .o_result        (result),
        .o_pc_redirect   (pc_redirect),
        .o_target        (target),
        .o_load_addr     (load_addr),
        .o_load_result   (load_result)
    );

endmodule

//--- design/rv_bus_master.sv
`timescale 1ns/10ps

module rv_bus_master (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_ack,
    input  logic             i_stall,
    input  rv_pkg::rv_word_t i_data,
    output logic             o_cyc,
    output logic             o_stb,
    output rv_pkg::rv_word_t o_addr,
    rv_mem_if.server         mem
);

    typedef enum logic {
        BM_IDLE,
        BM_BUSY
    } bm_state_e;

    bm_state_e state;
    logic      done;

    assign mem.req_ready = (state == BM_IDLE);
    // slave ends the cycle with ack while not stalling
    assign done = (state == BM_BUSY) && i_ack && !i_stall;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state         <= BM_IDLE;
            o_cyc         <= 1'b0;
            o_stb         <= 1'b0;
            o_addr        <= '0;
            mem.rsp_valid <= 1'b0;
        end else begin
            mem.rsp_valid <= 1'b0;
            case (state)
                BM_IDLE: begin
                    if (mem.req_valid) begin
                        o_cyc  <= 1'b1;
                        o_stb  <= 1'b1;
                        o_addr <= mem.req_addr;
                        state  <= BM_BUSY;
                    end
                end
                default: begin
                    // strobe accepted once stall is low
                    if (!i_stall) begin
                        o_stb <= 1'b0;
                    end
                    if (done) begin
                        o_cyc         <= 1'b0;
                        o_addr        <= '0;
                        mem.rsp_valid <= 1'b1;
                        state         <= BM_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (done) begin
            mem.rsp_data <= i_data;
        end
    end

endmodule

//--- design/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
    input  logic             i_clk,
    input  logic             i_rst,

    // wishbone read master
    input  logic             i_ack,
    input  logic             i_stall,
    input  rv_pkg::rv_word_t i_data,
    output logic             o_cyc,
    output logic             o_stb,
    output rv_pkg::rv_word_t o_addr
);

    rv_mem_if mem_if ();

    // sequencer is the only requester, so no arbitration
    rv_control u_control (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .mem   (mem_if.requester)
    );

    rv_bus_master u_bus_master (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_ack   (i_ack),
        .i_stall (i_stall),
        .i_data  (i_data),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_addr  (o_addr),
        .mem     (mem_if.server)
    );

endmodule

//--- verif/rv_core_properties.sv
`timescale 1ns/10ps

module rv_core_properties (
    input logic             i_clk,
    input logic             i_rst,
    input logic             i_stall,
    input logic             i_cyc,
    input logic             i_stb,
    input rv_pkg::rv_word_t i_addr
);

    // a strobe only inside a bus cycle
    stb_in_cycle: assert property (
        @(posedge i_clk) disable iff (i_rst) i_stb |-> i_cyc
    ) else $error("o_stb is high while o_cyc is low");

    // slave holds the address phase while stalling
    addr_held_in_stall: assert property (
        @(posedge i_clk) disable iff (i_rst) (i_stb && i_stall) |=> $stable(i_addr)
    ) else $error("o_addr changed while the slave was stalling");

    cyc_low_after_reset: assert property (
        @(posedge i_clk) i_rst |=> !i_cyc
    ) else $error("o_cyc is high in the cycle after reset");

endmodule

//--- verif/tb_top.sv
`timescale 1ns/10ps

`include "rv_config.svh"

module tb_top;

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 40;

    // rv32i major opcodes
    localparam logic [6:0] ENC_LUI    = 7'b0110111;
    localparam logic [6:0] ENC_AUIPC  = 7'b0010111;
    localparam logic [6:0] ENC_JAL    = 7'b1101111;
    localparam logic [6:0] ENC_JALR   = 7'b1100111;
    localparam logic [6:0] ENC_BRANCH = 7'b1100011;
    localparam logic [6:0] ENC_LOAD   = 7'b0000011;
    localparam logic [6:0] ENC_OP_IMM = 7'b0010011;
    localparam logic [6:0] ENC_OP     = 7'b0110011;

    logic        i_clk;
    logic        i_rst;
    logic        i_ack;
    logic        i_stall;
    logic [31:0] i_data;
    logic        o_cyc;
    logic        o_stb;
    logic [31:0] o_addr;

    integer      seed;
    int          errors;
    int          checks;
    int          cycle_count = 0;
    logic [31:0] regs [32];
    logic [31:0] pc;

    rv_core_top dut0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_ack   (i_ack),
        .i_stall (i_stall),
        .i_data  (i_data),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_addr  (o_addr)
    );

    bind rv_core_top rv_core_properties u_properties (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_stall (i_stall),
        .i_cyc   (o_cyc),
        .i_stb   (o_stb),
        .i_addr  (o_addr)
    );

    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles: the core stopped fetching", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $unsigned($random(seed));
        return r % n;
    endfunction

    // reference alu for the immediate and register groups
    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [1:0] low,
                                               input logic [31:0] w);
        logic [7:0]  bt;
        logic [15:0] hw;
        bt = w[8*low +: 8];
        hw = low[1] ? w[31:16] : w[15:0];
        case (f3)
            3'b000: return {{24{bt[7]}}, bt};
            3'b001: return {{16{hw[15]}}, hw};
            3'b100: return {24'b0, bt};
            3'b101: return {16'b0, hw};
            default: return w;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // bus slave for one access with random stall and ack delay
    task automatic serve_access(input string what, input logic [31:0] exp_addr,
                                input logic [31:0] rdata);
        int unsigned stall_n;
        int unsigned wait_n;
        stall_n = rand_below(3);
        wait_n  = rand_below(4);
        while (o_stb !== 1'b1) begin
            @(posedge i_clk);
            #1;
        end
        check_value({what, " o_addr"}, o_addr, exp_addr);
        repeat (stall_n) begin
            i_stall = 1'b1;
            @(posedge i_clk);
            #1;
            check_value({what, " o_stb under stall"}, {31'b0, o_stb}, 32'd1);
            check_value({what, " o_addr under stall"}, o_addr, exp_addr);
        end
        i_stall = 1'b0;
        repeat (wait_n) begin
            @(posedge i_clk);
            #1;
            // strobe taken, cycle stays open until ack
            check_value({what, " o_stb after accept"}, {31'b0, o_stb}, 32'd0);
            check_value({what, " o_cyc before ack"}, {31'b0, o_cyc}, 32'd1);
        end
        i_ack  = 1'b1;
        i_data = rdata;
        @(posedge i_clk);
        #1;
        i_ack  = 1'b0;
        i_data = '0;
        check_value({what, " o_cyc after ack"}, {31'b0, o_cyc}, 32'b0);
        check_value({what, " o_stb after ack"}, {31'b0, o_stb}, 32'b0);
        check_value({what, " o_addr after ack"}, o_addr, 32'b0);
    endtask

    // generate one instruction, serve its accesses and step the model
    task automatic run_instruction();
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic        taken;
        logic        is_load;
        logic [31:0] r;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] npc;
        logic [31:0] instr;
        logic [31:0] addr;
        logic [31:0] data;
        // x0 now and then so a write gets dropped
        rd      = (rand_below(16) == 0) ? 5'd0 : 5'(1 + rand_below(7));
        rs1     = 5'(rand_below(8));
        rs2     = 5'(rand_below(8));
        a       = regs[rs1];
        b       = regs[rs2];
        r       = $random(seed);
        npc     = pc + 32'd4;
        res     = '0;
        is_load = 1'b0;
        f3      = '0;
        addr    = '0;
        data    = '0;
        instr   = '0;
        imm     = (32'(rand_below(16)) - 32'd8) << 2;
        kind    = rand_below(10);
        case (kind)
            0: begin
                instr = {r[31:12], rd, ENC_LUI};
                res   = {r[31:12], 12'b0};
            end
            1: begin
                instr = {r[31:12], rd, ENC_AUIPC};
                res   = pc + {r[31:12], 12'b0};
            end
            2: begin
                instr = {imm[20], imm[10:1], imm[11], imm[19:12], rd, ENC_JAL};
                res   = npc;
                npc   = pc + imm;
            end
            3: begin
                instr = {imm[11:0], rs1, 3'b000, rd, ENC_JALR};
                res   = npc;
                npc   = (a + imm) & ~32'd1;
            end
            4: begin
                f3 = 3'(rand_below(6));
                if (f3 >= 3'd2) begin
                    f3 = f3 + 3'd2;
                end
                case (f3)
                    3'b000: taken = (a == b);
                    3'b001: taken = (a != b);
                    3'b100: taken = ($signed(a) < $signed(b));
                    3'b101: taken = ($signed(a) >= $signed(b));
                    3'b110: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                instr = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], ENC_BRANCH};
                rd    = 5'd0;
                if (taken) begin
                    npc = pc + imm;
                end
            end
            5, 6: begin
                f3  = 3'(rand_below(8));
                alt = 1'b0;
                imm = {{20{r[11]}}, r[11:0]};
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    alt = (f3 == 3'd5) && r[12];
                    imm = {21'b0, alt, 5'b0, r[4:0]};
                end
                instr = {imm[11:0], rs1, f3, rd, ENC_OP_IMM};
                res   = alu(f3, alt, a, imm);
            end
            7: begin
                f3    = 3'(rand_below(8));
                alt   = r[12] && (f3 == 3'd0 || f3 == 3'd5);
                instr = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, ENC_OP};
                res   = alu(f3, alt, a, b);
            end
            default: begin
                f3 = 3'(rand_below(5));
                if (f3 >= 3'd3) begin
                    f3 = f3 + 3'd1;
                end
                imm     = {{20{r[11]}}, r[11:0]};
                instr   = {imm[11:0], rs1, f3, rd, ENC_LOAD};
                addr    = a + imm;
                data    = $random(seed);
                is_load = 1'b1;
            end
        endcase
        serve_access("fetch", pc, instr);
        if (is_load) begin
            serve_access("load", addr, data);
            res = load_value(f3, addr[1:0], data);
        end
        if (rd != 5'd0) begin
            regs[rd] = res;
        end
        pc = npc;
    endtask

    initial begin
        seed    = 32'hd2fe;
        errors  = 0;
        checks  = 0;
        i_clk   = 1'b0;
        i_rst   = 1'b1;
        i_ack   = 1'b0;
        i_stall = 1'b0;
        i_data  = '0;
        pc      = `RV_RESET_PC;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        repeat (5) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            run_instruction();
        end
        $display("summary: %0d instructions, %0d checks, %0d errors", NUM_INSTR, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+design
design/rv_pkg.sv
design/rv_mem_if.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_control.sv
design/rv_bus_master.sv
design/rv_core_top.sv
verif/rv_core_properties.sv
verif/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_top \
    -f sim.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
